//--- source/rv_decode_consts.svh
`ifndef RV_DECODE_CONSTS_SVH
`define RV_DECODE_CONSTS_SVH

// major opcodes, instruction bits [6:2]
`define RV32_OPC_LOAD       5'b00000
`define RV32_OPC_STORE      5'b01000
`define RV32_OPC_OP_IMM     5'b00100
`define RV32_OPC_OP         5'b01100
`define RV32_OPC_LUI        5'b01101
`define RV32_OPC_AUIPC      5'b00101
`define RV32_OPC_BRANCH     5'b11000
`define RV32_OPC_JAL        5'b11011
`define RV32_OPC_JALR       5'b11001
`define RV32_OPC_SYSTEM     5'b11100

// low opcode bits of a 32-bit encoding
`define RV32_OPC_DET        2'b11

// field positions (lsb of each field)
`define RV32_OPC_LSB        2
`define RV32_RD_LSB         7
`define RV32_F3_LSB         12
`define RV32_RS1_LSB        15
`define RV32_RS2_LSB        20
`define RV32_F7_LSB         25
`define RV32_F12_LSB        20

// funct12 of SYSTEM with funct3 == 0
`define RV32_F12_ECALL      12'h000
`define RV32_F12_EBREAK     12'h001
`define RV32_F12_MRET       12'h302

// no compressed support, so always one word
`define RV32_PC_STEP        4

`endif

//--- source/rv_decode_pkg.sv
package rv_decode_pkg;

    typedef struct packed {
        logic add_override;
        logic op1_inv_or_ecmp_inv;
        logic op2_inverse;
        logic group_mux;
        logic div_mux;
    } alu_ctrl_t;

    // alu result group select
    typedef struct packed {
        logic cmp;
        logic bits;
        logic shift;
        logic arith;
    } alu_res_t;

    // writeback source
    typedef struct packed {
        logic memory;
        logic pc_next;
        logic alu;
    } res_src_t;

    typedef struct packed {
        logic r;
        logic i;
        logic j;
    } src_op2_t;

    // one bit per group or sub-op, filled by the classifier
    typedef struct packed {
        logic load;
        logic store;
        logic op_imm;
        logic op_reg;
        logic mul;
        logic lui;
        logic auipc;
        logic branch;
        logic jal;
        logic jalr;
        logic system;
        logic ecall;
        logic ebreak;
        logic mret;
        logic csr_req;
        logic sra_any;
        logic cmp_any;
        logic bits_any;
        logic shift_any;
        logic arith_any;
        logic full;
    } inst_class_t;

endpackage

//--- source/rv_decode_latch.sv
`timescale 1ns/1ps

module rv_decode_latch
#(
    parameter int IADDR_SPACE_BITS = 32
)
(
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_flush,
    input  logic                        i_stall,
    input  logic                        i_ready,
    input  logic [31:0]                 i_instruction,
    input  logic [IADDR_SPACE_BITS-1:0] i_pc,
    input  logic                        i_branch_pred,
    output logic [31:0]                 o_instruction,
    output logic [IADDR_SPACE_BITS-1:0] o_pc,
    output logic                        o_branch_pred,
    output logic                        o_valid
);

    logic [31:0] instr_gated;
    logic        clear;

    // empty slot decodes as all-zero
    assign instr_gated = i_ready ? i_instruction : 32'd0;
    assign clear       = i_rst | i_flush;

    always_ff @(posedge i_clk)
    begin
        if (clear)
        begin
            o_instruction <= '0;
            o_branch_pred <= 1'b0;
            o_valid       <= 1'b0;
        end
        else if (!i_stall)
        begin
            o_instruction <= instr_gated;
            o_branch_pred <= i_branch_pred;
            o_valid       <= i_ready;
        end
    end

    // pc only follows a real load
    always_ff @(posedge i_clk)
    begin
        if (!clear && !i_stall)
        begin
            o_pc <= i_pc;
        end
    end

    a_clear_empties_slot: assert property (@(posedge i_clk)
        clear |=> (!o_valid && (o_instruction == 32'd0)));

endmodule

//--- source/rv_imm_gen.sv
`timescale 1ns/1ps

module rv_imm_gen
(
    input  logic [31:0]               i_instruction,
    input  rv_decode_pkg::inst_class_t i_class,
    output logic [31:0]               o_imm_i,
    output logic [31:0]               o_imm_j
);

    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    assign imm_i = {{21{i_instruction[31]}}, i_instruction[30:20]};
    assign imm_s = {{21{i_instruction[31]}}, i_instruction[30:25], i_instruction[11:7]};

    // branch and jump offsets are half-word aligned
    assign imm_b = {{20{i_instruction[31]}}, i_instruction[7], i_instruction[30:25],
                    i_instruction[11:8], 1'b0};
    assign imm_j = {{12{i_instruction[31]}}, i_instruction[19:12], i_instruction[20],
                    i_instruction[30:21], 1'b0};
    assign imm_u = {i_instruction[31:12], 12'd0};

    always_comb
    begin
        if (i_class.lui || i_class.auipc)
        begin
            o_imm_i = imm_u;
        end
        else if (i_class.store)
        begin
            o_imm_i = imm_s;
        end
        else
        begin
            o_imm_i = imm_i;
        end
    end

    assign o_imm_j = i_class.jal ? imm_j : imm_b;

endmodule

//--- source/rv_inst_classify.sv
`timescale 1ns/1ps

`include "rv_decode_consts.svh"

module rv_inst_classify
#(
    parameter logic EXTENSION_M     = 1'b1,
    parameter logic EXTENSION_Zicsr = 1'b1
)
(
    input  logic [31:0]                i_instruction,
    input  logic                       i_valid,
    output rv_decode_pkg::inst_class_t o_class,
    output logic                       o_supported
);

    logic [4:0]  opc;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] funct12;
    logic        full;
    logic        alu_grp;
    logic        sys_f3_zero;

    assign opc     = i_instruction[`RV32_OPC_LSB +: 5];
    assign funct3  = i_instruction[`RV32_F3_LSB +: 3];
    assign funct7  = i_instruction[`RV32_F7_LSB +: 7];
    assign funct12 = i_instruction[`RV32_F12_LSB +: 12];
    assign full    = (i_instruction[1:0] == `RV32_OPC_DET);

    // major groups
    assign o_class.full    = full;
    assign o_class.load    = full & (opc == `RV32_OPC_LOAD);
    assign o_class.store   = full & (opc == `RV32_OPC_STORE);
    assign o_class.op_imm  = full & (opc == `RV32_OPC_OP_IMM);
    assign o_class.op_reg  = full & (opc == `RV32_OPC_OP) & ~funct7[0];
    assign o_class.mul     = full & (opc == `RV32_OPC_OP) & funct7[0] & EXTENSION_M;
    assign o_class.lui     = full & (opc == `RV32_OPC_LUI);
    assign o_class.auipc   = full & (opc == `RV32_OPC_AUIPC);
    assign o_class.branch  = full & (opc == `RV32_OPC_BRANCH);
    assign o_class.jal     = full & (opc == `RV32_OPC_JAL);
    assign o_class.jalr    = full & (opc == `RV32_OPC_JALR) & (funct3 == 3'b000);
    assign o_class.system  = full & (opc == `RV32_OPC_SYSTEM);

    // privileged ops share funct3 == 0
    assign sys_f3_zero     = o_class.system & (funct3 == 3'b000);
    assign o_class.ecall   = sys_f3_zero & (funct12 == `RV32_F12_ECALL);
    assign o_class.ebreak  = sys_f3_zero & (funct12 == `RV32_F12_EBREAK);
    assign o_class.mret    = sys_f3_zero & (funct12 == `RV32_F12_MRET);
    assign o_class.csr_req = o_class.system & (funct3 != 3'b000) & EXTENSION_Zicsr;

    // sub-ops of the integer alu groups
    assign alu_grp = o_class.op_imm | o_class.op_reg;

    assign o_class.sra_any   = alu_grp & (funct3 == 3'b101) & funct7[5];
    assign o_class.shift_any = alu_grp & (funct3[1:0] == 2'b01);
    assign o_class.cmp_any   = o_class.branch | (alu_grp & (funct3[2:1] == 2'b01));
    assign o_class.bits_any  = alu_grp & funct3[2] & (funct3[1:0] != 2'b01);
    assign o_class.arith_any = (alu_grp & (funct3 == 3'b000)) | o_class.load
                             | o_class.store;

    // an empty slot is never flagged
    always_comb
    begin
        o_supported = ~i_valid;
        o_supported = o_supported | o_class.load | o_class.store | o_class.op_imm;
        o_supported = o_supported | o_class.op_reg | o_class.mul;
        o_supported = o_supported | o_class.lui | o_class.auipc | o_class.branch;
        o_supported = o_supported | o_class.jal | o_class.jalr;
        o_supported = o_supported | o_class.ecall | o_class.ebreak | o_class.csr_req;
        o_supported = o_supported | (o_class.mret & EXTENSION_Zicsr);
    end

endmodule

//--- source/rv_ctrl_gen.sv
`timescale 1ns/1ps

module rv_ctrl_gen
(
    input  rv_decode_pkg::inst_class_t i_class,
    input  logic [2:0]                 i_funct3,
    input  logic                       i_funct7_b5,
    input  logic                       i_stall,
    output rv_decode_pkg::alu_ctrl_t   o_alu_ctrl,
    output rv_decode_pkg::alu_res_t    o_alu_res,
    output rv_decode_pkg::res_src_t    o_res_src,
    output logic                       o_op1_src,
    output rv_decode_pkg::src_op2_t    o_op2_src,
    output logic                       o_reg_write,
    output logic                       o_csr_imm_sel,
    output logic                       o_csr_write,
    output logic                       o_csr_set,
    output logic                       o_csr_clear,
    output logic                       o_csr_read
);

    logic addr_calc;
    logic slt_like;
    logic imm_op2;

    // alu only forms an address or a sum
    assign addr_calc = i_class.lui | i_class.auipc | i_class.jal | i_class.load
                     | i_class.store;
    assign slt_like  = (i_class.op_imm | i_class.op_reg) & (i_funct3[2:1] == 2'b01);
    assign imm_op2   = i_class.jalr | i_class.load | i_class.op_imm | i_class.lui
                     | i_class.auipc | i_class.store;

    assign o_alu_ctrl.add_override        = addr_calc;
    assign o_alu_ctrl.op1_inv_or_ecmp_inv = i_class.branch & i_funct3[0];
    assign o_alu_ctrl.group_mux           = i_class.mul;
    assign o_alu_ctrl.div_mux             = i_class.mul & i_funct3[2];

    // compares and arithmetic shift need inverted op2, sub comes from funct7
    always_comb
    begin
        if (i_class.branch || slt_like || i_class.sra_any)
        begin
            o_alu_ctrl.op2_inverse = 1'b1;
        end
        else if (addr_calc || i_class.op_imm)
        begin
            o_alu_ctrl.op2_inverse = 1'b0;
        end
        else
        begin
            o_alu_ctrl.op2_inverse = i_funct7_b5;
        end
    end

    assign o_alu_res.cmp   = i_class.cmp_any;
    assign o_alu_res.bits  = i_class.bits_any;
    assign o_alu_res.shift = i_class.shift_any;
    assign o_alu_res.arith = i_class.arith_any;

    assign o_res_src.memory  = i_class.load;
    assign o_res_src.pc_next = i_class.jal | i_class.jalr;
    assign o_res_src.alu     = ~(i_class.load | i_class.jal | i_class.jalr);

    assign o_op1_src   = i_class.auipc | i_class.jal;
    assign o_op2_src.j = i_class.jal;
    assign o_op2_src.i = imm_op2;
    assign o_op2_src.r = ~(imm_op2 | i_class.jal);

    assign o_reg_write = i_class.full & ~(i_class.branch | i_class.store);

    // csr strobes, the writes must not fire twice across a stall
    assign o_csr_imm_sel = i_class.csr_req & i_funct3[2];
    assign o_csr_read    = i_class.system & (i_funct3 != 3'b000);
    assign o_csr_write   = i_class.system & (i_funct3[1:0] == 2'b01) & ~i_stall;
    assign o_csr_set     = i_class.system & (i_funct3[1:0] == 2'b10) & ~i_stall;
    assign o_csr_clear   = i_class.system & (i_funct3[1:0] == 2'b11) & ~i_stall;

endmodule

//--- source/rv_decode.sv
`timescale 1ns/1ps

`include "rv_decode_consts.svh"

module rv_decode
#(
    parameter int   IADDR_SPACE_BITS = 32,
    parameter logic EXTENSION_M      = 1'b1,
    parameter logic EXTENSION_Zicsr  = 1'b1
)
(
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_stall,
    input  logic                        i_flush,
    input  logic                        i_ready,
    input  logic [31:0]                 i_instruction,
    input  logic [IADDR_SPACE_BITS-1:0] i_pc,
    input  logic                        i_branch_pred,
    output logic [4:0]                  o_rs1,
    output logic [4:0]                  o_rs2,
    output logic [4:0]                  o_rd,
    output logic [2:0]                  o_funct3,
    output logic [31:0]                 o_imm_i,
    output logic [31:0]                 o_imm_j,
    output logic [IADDR_SPACE_BITS-1:0] o_pc,
    output logic [IADDR_SPACE_BITS-1:0] o_pc_next,
    output logic [IADDR_SPACE_BITS-1:0] o_csr_pc_next,
    output logic                        o_branch_pred,
    output rv_decode_pkg::alu_ctrl_t    o_alu_ctrl,
    output rv_decode_pkg::alu_res_t     o_alu_res,
    output rv_decode_pkg::res_src_t     o_res_src,
    output logic                        o_op1_src,
    output rv_decode_pkg::src_op2_t     o_op2_src,
    output logic                        o_reg_write,
    output logic                        o_csr_imm_sel,
    output logic                        o_csr_write,
    output logic                        o_csr_set,
    output logic                        o_csr_clear,
    output logic                        o_csr_read,
    output logic [11:0]                 o_csr_idx,
    output logic [4:0]                  o_csr_imm,
    output logic                        o_csr_ebreak,
    output logic                        o_inst_mret,
    output logic                        o_inst_jal,
    output logic                        o_inst_jalr,
    output logic                        o_inst_branch,
    output logic                        o_inst_store,
    output logic                        o_inst_supported,
    output logic                        o_inst_csr_req
);

    logic [31:0]                 instr;
    logic                        valid;
    logic [IADDR_SPACE_BITS-1:0] pc_next;
    rv_decode_pkg::inst_class_t  cls;

    rv_decode_latch #(
        .IADDR_SPACE_BITS (IADDR_SPACE_BITS)
    ) u_latch (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_flush       (i_flush),
        .i_stall       (i_stall),
        .i_ready       (i_ready),
        .i_instruction (i_instruction),
        .i_pc          (i_pc),
        .i_branch_pred (i_branch_pred),
        .o_instruction (instr),
        .o_pc          (o_pc),
        .o_branch_pred (o_branch_pred),
        .o_valid       (valid)
    );

    rv_inst_classify #(
        .EXTENSION_M     (EXTENSION_M),
        .EXTENSION_Zicsr (EXTENSION_Zicsr)
    ) u_classify (
        .i_instruction (instr),
        .i_valid       (valid),
        .o_class       (cls),
        .o_supported   (o_inst_supported)
    );

    rv_imm_gen u_imm (
        .i_instruction (instr),
        .i_class       (cls),
        .o_imm_i       (o_imm_i),
        .o_imm_j       (o_imm_j)
    );

    rv_ctrl_gen u_ctrl (
        .i_class       (cls),
        .i_funct3      (instr[`RV32_F3_LSB +: 3]),
        .i_funct7_b5   (instr[30]),
        .i_stall       (i_stall),
        .o_alu_ctrl    (o_alu_ctrl),
        .o_alu_res     (o_alu_res),
        .o_res_src     (o_res_src),
        .o_op1_src     (o_op1_src),
        .o_op2_src     (o_op2_src),
        .o_reg_write   (o_reg_write),
        .o_csr_imm_sel (o_csr_imm_sel),
        .o_csr_write   (o_csr_write),
        .o_csr_set     (o_csr_set),
        .o_csr_clear   (o_csr_clear),
        .o_csr_read    (o_csr_read)
    );

    // lui has no rs1, the field holds immediate bits
    assign o_rs1    = cls.lui ? 5'd0 : instr[`RV32_RS1_LSB +: 5];
    assign o_rs2    = instr[`RV32_RS2_LSB +: 5];
    assign o_rd     = instr[`RV32_RD_LSB +: 5];
    assign o_funct3 = instr[`RV32_F3_LSB +: 3];

    assign o_csr_idx    = instr[`RV32_F12_LSB +: 12];
    assign o_csr_imm    = instr[`RV32_RS1_LSB +: 5];
    assign o_csr_ebreak = cls.ebreak;

    assign pc_next       = o_pc + IADDR_SPACE_BITS'(`RV32_PC_STEP);
    assign o_pc_next     = pc_next;
    assign o_csr_pc_next = pc_next;

    assign o_inst_mret    = cls.mret;
    assign o_inst_jal     = cls.jal;
    assign o_inst_jalr    = cls.jalr;
    assign o_inst_branch  = cls.branch;
    assign o_inst_store   = cls.store;
    assign o_inst_csr_req = cls.csr_req;

endmodule

//--- dv/rv_decode_tb.sv
`timescale 1ns/1ps

module rv_decode_tb;

    localparam int CLK_PERIOD = 8;
    localparam int N_FIXED    = 28;
    localparam int N_RAND     = 8;
    localparam int N_ROWS     = N_FIXED + N_RAND;
    localparam int WATCHDOG   = N_ROWS * 10 + 100;

    // stim is {ready, stall, flush, branch_pred}
    // misc is {op1_src, reg_write, supported, branch_pred}
    // csr is {imm_sel, write, set, clear, read}
    // flags is {mret, ebreak, csr_req, jal, jalr, branch, store}
    typedef struct packed {
        logic [31:0] instr;
        logic [3:0]  stim;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm_i;
        logic [31:0] imm_j;
        logic [3:0]  alu_res;
        logic [2:0]  res_src;
        logic [2:0]  op2_src;
        logic [3:0]  misc;
        logic [4:0]  csr;
        logic [6:0]  flags;
    } row_t;

    logic        i_clk = 1'b0;
    logic        i_rst;
    logic        i_stall;
    logic        i_flush;
    logic        i_ready;
    logic [31:0] i_instruction;
    logic [31:0] i_pc;
    logic        i_branch_pred;

    logic [4:0]  o_rs1;
    logic [4:0]  o_rs2;
    logic [4:0]  o_rd;
    logic [2:0]  o_funct3;
    logic [31:0] o_imm_i;
    logic [31:0] o_imm_j;
    logic [31:0] o_pc;
    logic [31:0] o_pc_next;
    logic [31:0] o_csr_pc_next;
    logic        o_branch_pred;
    logic [4:0]  o_alu_ctrl;
    logic [3:0]  o_alu_res;
    logic [2:0]  o_res_src;
    logic        o_op1_src;
    logic [2:0]  o_op2_src;
    logic        o_reg_write;
    logic        o_csr_imm_sel;
    logic        o_csr_write;
    logic        o_csr_set;
    logic        o_csr_clear;
    logic        o_csr_read;
    logic [11:0] o_csr_idx;
    logic [4:0]  o_csr_imm;
    logic        o_csr_ebreak;
    logic        o_inst_mret;
    logic        o_inst_jal;
    logic        o_inst_jalr;
    logic        o_inst_branch;
    logic        o_inst_store;
    logic        o_inst_supported;
    logic        o_inst_csr_req;

    row_t        rows [N_ROWS];
    string       names [N_ROWS];
    int          n_rows;
    int          errors;
    integer      seed;
    string       cur_name;
    logic [31:0] exp_instr;
    logic [31:0] exp_pc;

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    rv_decode dut0 (
        .i_clk            (i_clk),
        .i_rst            (i_rst),
        .i_stall          (i_stall),
        .i_flush          (i_flush),
        .i_ready          (i_ready),
        .i_instruction    (i_instruction),
        .i_pc             (i_pc),
        .i_branch_pred    (i_branch_pred),
        .o_rs1            (o_rs1),
        .o_rs2            (o_rs2),
        .o_rd             (o_rd),
        .o_funct3         (o_funct3),
        .o_imm_i          (o_imm_i),
        .o_imm_j          (o_imm_j),
        .o_pc             (o_pc),
        .o_pc_next        (o_pc_next),
        .o_csr_pc_next    (o_csr_pc_next),
        .o_branch_pred    (o_branch_pred),
        .o_alu_ctrl       (o_alu_ctrl),
        .o_alu_res        (o_alu_res),
        .o_res_src        (o_res_src),
        .o_op1_src        (o_op1_src),
        .o_op2_src        (o_op2_src),
        .o_reg_write      (o_reg_write),
        .o_csr_imm_sel    (o_csr_imm_sel),
        .o_csr_write      (o_csr_write),
        .o_csr_set        (o_csr_set),
        .o_csr_clear      (o_csr_clear),
        .o_csr_read       (o_csr_read),
        .o_csr_idx        (o_csr_idx),
        .o_csr_imm        (o_csr_imm),
        .o_csr_ebreak     (o_csr_ebreak),
        .o_inst_mret      (o_inst_mret),
        .o_inst_jal       (o_inst_jal),
        .o_inst_jalr      (o_inst_jalr),
        .o_inst_branch    (o_inst_branch),
        .o_inst_store     (o_inst_store),
        .o_inst_supported (o_inst_supported),
        .o_inst_csr_req   (o_inst_csr_req)
    );

    task automatic check_value(input string field, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
        if (act_val !== exp_val)
        begin
            errors++;
            $display("error: %s %s expected %h actual %h", cur_name, field, exp_val, act_val);
            $display("TESTS FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // alu control {add_override, op1_inv, op2_inverse, group_mux, div_mux} per row
    function automatic logic [4:0] alu_ctrl_for(input string name);
        case (name)
            "sw", "lui", "jal", "lw", "auipc": return 5'b10000;
            "beq", "sra", "slti":              return 5'b00100;
            "mul":                             return 5'b00010;
            "div":                             return 5'b00011;
            default:                           return 5'b00000;
        endcase
    endfunction

    // pc of each row steps by one word from 0x100
    task automatic add_row(input string name, input logic [31:0] instr, input logic [3:0] stim,
                           input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
                           input logic [31:0] imm_i, input logic [31:0] imm_j,
                           input logic [3:0] alu_res, input logic [2:0] res_src,
                           input logic [2:0] op2_src, input logic [3:0] misc,
                           input logic [4:0] csr, input logic [6:0] flags);
        names[n_rows] = name;
        rows[n_rows]  = '{instr, stim, 32'h100 + 32'(n_rows * 4), rd, rs1, rs2, imm_i, imm_j,
                          alu_res, res_src, op2_src, misc, csr, flags};
        n_rows++;
    endtask

    task automatic build_table();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        add_row("addi", 32'hffd30293, 4'b1000, 5, 6, 29, 32'hfffffffd, 32'hffffffe4,
                4'b0001, 3'b001, 3'b010, 4'b0110, 5'b00000, 7'b0000000);
        add_row("sw", 32'h00742a23, 4'b1000, 20, 8, 7, 32'h14, 32'h14,
                4'b0001, 3'b001, 3'b010, 4'b0010, 5'b00000, 7'b0000001);
        add_row("beq", 32'hfe208ce3, 4'b1001, 25, 1, 2, 32'hffffffe2, 32'hfffffff8,
                4'b1000, 3'b001, 3'b100, 4'b0011, 5'b00000, 7'b0000010);
        add_row("flush", 32'h00c58533, 4'b1011, 0, 0, 0, 32'h0, 32'h0,
                4'b0000, 3'b001, 3'b100, 4'b0010, 5'b00000, 7'b0000000);
        add_row("lui", 32'h123454b7, 4'b1000, 9, 0, 3, 32'h12345000, 32'h928,
                4'b0000, 3'b001, 3'b010, 4'b0110, 5'b00000, 7'b0000000);
        add_row("jal", 32'h001000ef, 4'b1000, 1, 0, 1, 32'h1, 32'h800,
                4'b0000, 3'b010, 3'b001, 4'b1110, 5'b00000, 7'b0001000);
        add_row("jalr", 32'h00c201e7, 4'b1000, 3, 4, 12, 32'hc, 32'h802,
                4'b0000, 3'b010, 3'b010, 4'b0110, 5'b00000, 7'b0000100);
        add_row("add", 32'h00c58533, 4'b1000, 10, 11, 12, 32'hc, 32'ha,
                4'b0001, 3'b001, 3'b100, 4'b0110, 5'b00000, 7'b0000000);
        add_row("sra", 32'h40f756b3, 4'b1000, 13, 14, 15, 32'h40f, 32'hc0c,
                4'b0010, 3'b001, 3'b100, 4'b0110, 5'b00000, 7'b0000000);
        add_row("slti", 32'h0051a113, 4'b1000, 2, 3, 5, 32'h5, 32'h2,
                4'b1000, 3'b001, 3'b010, 4'b0110, 5'b00000, 7'b0000000);
        add_row("xor", 32'h0062c233, 4'b1000, 4, 5, 6, 32'h6, 32'h4,
                4'b0100, 3'b001, 3'b100, 4'b0110, 5'b00000, 7'b0000000);
        add_row("lw", 32'h0104a403, 4'b1000, 8, 9, 16, 32'h10, 32'h8,
                4'b0001, 3'b100, 3'b010, 4'b0110, 5'b00000, 7'b0000000);
        add_row("auipc", 32'h00001317, 4'b1000, 6, 0, 0, 32'h1000, 32'h6,
                4'b0000, 3'b001, 3'b010, 4'b1110, 5'b00000, 7'b0000000);
        add_row("mul", 32'h029403b3, 4'b1000, 7, 8, 9, 32'h29, 32'h826,
                4'b0000, 3'b001, 3'b100, 4'b0110, 5'b00000, 7'b0000000);
        add_row("div", 32'h02c5c533, 4'b1000, 10, 11, 12, 32'h2c, 32'h2a,
                4'b0000, 3'b001, 3'b100, 4'b0110, 5'b00000, 7'b0000000);
        add_row("csrrw", 32'h300110f3, 4'b1000, 1, 2, 0, 32'h300, 32'hb00,
                4'b0000, 3'b001, 3'b100, 4'b0110, 5'b01001, 7'b0010000);
        // stalled, the csrrw stays but its write strobe drops
        add_row("csrrw_stall", 32'hffd30293, 4'b1101, 1, 2, 0, 32'h300, 32'hb00,
                4'b0000, 3'b001, 3'b100, 4'b0110, 5'b00001, 7'b0010000);
        add_row("csrrs", 32'h341221f3, 4'b1000, 3, 4, 1, 32'h341, 32'hb42,
                4'b0000, 3'b001, 3'b100, 4'b0110, 5'b00101, 7'b0010000);
        add_row("csrrc", 32'h342332f3, 4'b1000, 5, 6, 2, 32'h342, 32'hb44,
                4'b0000, 3'b001, 3'b100, 4'b0110, 5'b00011, 7'b0010000);
        add_row("csrrwi", 32'h3054d3f3, 4'b1000, 7, 9, 5, 32'h305, 32'hb06,
                4'b0000, 3'b001, 3'b100, 4'b0110, 5'b11001, 7'b0010000);
        add_row("csrrsi", 32'h3401e473, 4'b1000, 8, 3, 0, 32'h340, 32'h348,
                4'b0000, 3'b001, 3'b100, 4'b0110, 5'b10101, 7'b0010000);
        add_row("csrrsi_stall", 32'h00000073, 4'b1100, 8, 3, 0, 32'h340, 32'h348,
                4'b0000, 3'b001, 3'b100, 4'b0110, 5'b10001, 7'b0010000);
        add_row("csrrci", 32'h3440f4f3, 4'b1000, 9, 1, 4, 32'h344, 32'hb48,
                4'b0000, 3'b001, 3'b100, 4'b0110, 5'b10011, 7'b0010000);
        add_row("ebreak", 32'h00100073, 4'b1000, 0, 0, 1, 32'h1, 32'h0,
                4'b0000, 3'b001, 3'b100, 4'b0110, 5'b00000, 7'b0100000);
        add_row("mret", 32'h30200073, 4'b1000, 0, 0, 2, 32'h302, 32'h300,
                4'b0000, 3'b001, 3'b100, 4'b0110, 5'b00000, 7'b1000000);
        add_row("not_ready", 32'hffd30293, 4'b0000, 0, 0, 0, 32'h0, 32'h0,
                4'b0000, 3'b001, 3'b100, 4'b0010, 5'b00000, 7'b0000000);
        add_row("flw", 32'h00812087, 4'b1000, 1, 2, 8, 32'h8, 32'h800,
                4'b0000, 3'b001, 3'b100, 4'b0100, 5'b00000, 7'b0000000);
        add_row("compressed", 32'h00004501, 4'b1000, 10, 0, 0, 32'h0, 32'ha,
                4'b0000, 3'b001, 3'b100, 4'b0000, 5'b00000, 7'b0000000);
        // or with random registers
        for (int k = 0; k < N_RAND; k++)
        begin
            r   = $random(seed);
            rd  = r[4:0];
            rs1 = r[9:5];
            rs2 = r[14:10];
            add_row($sformatf("or_rand%0d", k), {7'd0, rs2, rs1, 3'b110, rd, 7'b0110011},
                    4'b1000, rd, rs1, rs2, {27'd0, rs2}, {20'd0, rd[0], 6'd0, rd[4:1], 1'b0},
                    4'b0100, 3'b001, 3'b100, 4'b0110, 5'b00000, 7'b0000000);
        end
    endtask

    task automatic drive_row(input int idx);
        i_instruction = rows[idx].instr;
        i_ready       = rows[idx].stim[3];
        i_stall       = rows[idx].stim[2];
        i_flush       = rows[idx].stim[1];
        i_branch_pred = rows[idx].stim[0];
        i_pc          = rows[idx].pc;
    endtask

    task automatic check_row(input int idx);
        row_t row;
        row      = rows[idx];
        cur_name = names[idx];
        // register model, flush wins over stall
        if (row.stim[1])
        begin
            exp_instr = 32'd0;
        end
        else if (!row.stim[2])
        begin
            exp_instr = row.stim[3] ? row.instr : 32'd0;
            exp_pc    = row.pc;
        end
        check_value("rd", row.rd, o_rd);
        check_value("rs1", row.rs1, o_rs1);
        check_value("rs2", row.rs2, o_rs2);
        check_value("imm_i", row.imm_i, o_imm_i);
        check_value("imm_j", row.imm_j, o_imm_j);
        check_value("alu_ctrl", alu_ctrl_for(cur_name), o_alu_ctrl);
        check_value("alu_res", row.alu_res, o_alu_res);
        check_value("res_src", row.res_src, o_res_src);
        check_value("op2_src", row.op2_src, o_op2_src);
        check_value("misc", row.misc, {o_op1_src, o_reg_write, o_inst_supported, o_branch_pred});
        check_value("csr", row.csr,
                    {o_csr_imm_sel, o_csr_write, o_csr_set, o_csr_clear, o_csr_read});
        check_value("flags", row.flags, {o_inst_mret, o_csr_ebreak, o_inst_csr_req,
                    o_inst_jal, o_inst_jalr, o_inst_branch, o_inst_store});
        check_value("funct3", exp_instr[14:12], o_funct3);
        check_value("csr_idx", exp_instr[31:20], o_csr_idx);
        check_value("csr_imm", exp_instr[19:15], o_csr_imm);
        check_value("pc", exp_pc, o_pc);
        check_value("pc_next", exp_pc + 32'd4, o_pc_next);
        check_value("csr_pc_next", exp_pc + 32'd4, o_csr_pc_next);
    endtask

    initial
    begin
        #(WATCHDOG * CLK_PERIOD);
        $display("watchdog: the decode tests did not finish in the allowed time");
        $display("TESTS FAILED");
        $fatal(1, "simulation hung");
    end

    initial
    begin
        seed          = 32'he936;
        errors        = 0;
        n_rows        = 0;
        exp_instr     = 32'd0;
        exp_pc        = 32'd0;
        i_rst         = 1'b1;
        i_stall       = 1'b0;
        i_flush       = 1'b0;
        i_ready       = 1'b1;
        i_instruction = 32'hffd30293;
        i_pc          = 32'h80;
        i_branch_pred = 1'b1;
        build_table();

        repeat (3) @(posedge i_clk);
        #1;
        i_rst    = 1'b0;
        cur_name = "reset";
        check_value("reg_write", 0, o_reg_write);
        check_value("supported", 1, o_inst_supported);
        check_value("branch_pred", 0, o_branch_pred);
        check_value("flags", 0, {o_inst_mret, o_csr_ebreak, o_inst_csr_req,
                    o_inst_jal, o_inst_jalr, o_inst_branch, o_inst_store});
        check_value("csr", 0, {o_csr_write, o_csr_set, o_csr_clear, o_csr_read});

        for (int i = 0; i < n_rows; i++)
        begin
            drive_row(i);
            @(posedge i_clk);
            #1;
            check_row(i);
        end

        if (errors == 0)
        begin
            $display("TESTS PASSED");
        end
        else
        begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+source
source/rv_decode_pkg.sv
source/rv_decode_latch.sv
source/rv_imm_gen.sv
source/rv_inst_classify.sv
source/rv_ctrl_gen.sv
source/rv_decode.sv
dv/rv_decode_tb.sv

//--- Bender.yml
package:
  name: rv_decode

sources:
  - include_dirs:
      - source
    files:
      - source/rv_decode_pkg.sv
      - source/rv_decode_latch.sv
      - source/rv_imm_gen.sv
      - source/rv_inst_classify.sv
      - source/rv_ctrl_gen.sv
      - source/rv_decode.sv
  - target: test
    files:
      - dv/rv_decode_tb.sv
